// ==== hdl/rv_isa_pkg.sv ====
// RV64I encoding definitions for the integer execute stage
// imported by each unit that decodes instruction fields
`default_nettype none

package rv_isa_pkg;

    localparam int unsigned XLEN       = 64;
    localparam int unsigned INST_W     = 32;
    localparam int unsigned REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       xlen_t;
    typedef logic [INST_W-1:0]     inst_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        LOAD      = 7'b0000011,
        OP_IMM    = 7'b0010011,
        OP_IMM_32 = 7'b0011011,
        STORE     = 7'b0100011,
        OP        = 7'b0110011,
        OP_32     = 7'b0111011,
        BRANCH    = 7'b1100011
    } opcode_e;

    typedef enum logic [2:0] {
        ADD_SUB = 3'b000,
        SLL     = 3'b001,
        SLT     = 3'b010,
        SLTU    = 3'b011,
        XOR     = 3'b100,
        SR      = 3'b101,   // srl or sra by funct7
        OR      = 3'b110,
        AND     = 3'b111
    } alu_funct3_e;

    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } branch_funct3_e;

    // funct3 of loads and stores
    typedef enum logic [2:0] {
        BYTE   = 3'b000,
        HALF   = 3'b001,
        WORD   = 3'b010,
        DOUBLE = 3'b011,
        BYTE_U = 3'b100,
        HALF_U = 3'b101,
        WORD_U = 3'b110
    } mem_size_e;

    localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
    localparam logic [6:0] FUNCT7_ALT  = 7'b0100000;  // sub and sra

endpackage

`default_nettype wire

// ==== hdl/ex_stage_pkg.sv ====
// pipeline structs and memory credit constants of the execute stage
// shared by the stage units and the testbench
`default_nettype none

package ex_stage_pkg;

    import rv_isa_pkg::*;

    // requests the memory side can hold at once
    localparam int unsigned MEM_CREDITS = 2;
    localparam int unsigned CREDIT_W    = $clog2(MEM_CREDITS + 1);

    typedef logic [CREDIT_W-1:0] credit_cnt_t;

    typedef struct packed {
        inst_t     inst;
        xlen_t     pc;
        xlen_t     op1;
        xlen_t     op2;     // I immediate for I-type
        reg_addr_t rd;
        logic      rd_we;
    } ex_req_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        xlen_t     data;
    } wb_t;

    typedef struct packed {
        logic  valid;
        xlen_t target;
    } redirect_t;

    typedef struct packed {
        logic      valid;
        logic      we;
        mem_size_e size;
        xlen_t     addr;
        xlen_t     wdata;
        reg_addr_t rd;      // load destination
    } mem_req_t;

endpackage

`default_nettype wire

// ==== hdl/int_alu.sv ====
// RV64I register and immediate ALU, including the 32-bit W forms
// result, rd and valid are registered one cycle after accept_i
`timescale 1ns/1ps
`default_nettype none

module int_alu (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  accept_i,
    input  ex_stage_pkg::ex_req_t req_i,
    output ex_stage_pkg::wb_t     wb_o
);

    import rv_isa_pkg::*;

    opcode_e     opcode;
    alu_funct3_e funct3;
    logic [6:0]  funct7;
    logic        is_alu;
    logic        is_imm;
    logic        is_w;
    logic        f7_base;
    logic        f7_alt;
    logic        logic_ok;
    logic        legal;
    logic [5:0]  shamt;
    xlen_t       add_sub;
    xlen_t       sll_d;
    xlen_t       srl_d;
    xlen_t       sra_d;
    logic [31:0] sll_w;
    logic [31:0] srl_w;
    logic [31:0] sra_w;
    xlen_t       result;

    function automatic xlen_t sext_w(input logic [31:0] v);
        return {{32{v[31]}}, v};
    endfunction

    assign opcode = opcode_e'(req_i.inst[6:0]);
    assign funct3 = alu_funct3_e'(req_i.inst[14:12]);
    assign funct7 = req_i.inst[31:25];
    assign is_alu = opcode inside {OP_IMM, OP, OP_IMM_32, OP_32};
    assign is_imm = (opcode == OP_IMM) || (opcode == OP_IMM_32);
    assign is_w   = (opcode == OP_IMM_32) || (opcode == OP_32);

    // 64-bit immediate shifts borrow inst[25] for shamt[5]
    assign f7_base = (opcode == OP_IMM) ? (funct7[6:1] == FUNCT7_BASE[6:1])
                                        : (funct7 == FUNCT7_BASE);
    assign f7_alt  = (opcode == OP_IMM) ? (funct7[6:1] == FUNCT7_ALT[6:1])
                                        : (funct7 == FUNCT7_ALT);
    assign logic_ok = !is_w && (is_imm || f7_base);   // no W form of these

    assign shamt   = is_imm ? req_i.inst[25:20] : req_i.op2[5:0];
    assign add_sub = (!is_imm && f7_alt) ? req_i.op1 - req_i.op2
                                         : req_i.op1 + req_i.op2;
    assign sll_d = req_i.op1 << shamt;
    assign srl_d = req_i.op1 >> shamt;
    assign sra_d = $signed(req_i.op1) >>> shamt;
    assign sll_w = req_i.op1[31:0] << shamt[4:0];
    assign srl_w = req_i.op1[31:0] >> shamt[4:0];
    assign sra_w = $signed(req_i.op1[31:0]) >>> shamt[4:0];

    always_comb begin
        legal  = 1'b0;
        result = add_sub;
        case (funct3)
            ADD_SUB: begin
                legal  = is_imm || f7_base || f7_alt;
                result = is_w ? sext_w(add_sub[31:0]) : add_sub;
            end
            SLL: begin
                legal  = f7_base;
                result = is_w ? sext_w(sll_w) : sll_d;
            end
            SR: begin
                legal = f7_base || f7_alt;
                if (is_w) begin
                    result = sext_w(f7_alt ? sra_w : srl_w);
                end else begin
                    result = f7_alt ? sra_d : srl_d;
                end
            end
            SLT: begin
                legal  = logic_ok;
                result = xlen_t'($signed(req_i.op1) < $signed(req_i.op2));
            end
            SLTU: begin
                legal  = logic_ok;
                result = xlen_t'(req_i.op1 < req_i.op2);
            end
            XOR: begin
                legal  = logic_ok;
                result = req_i.op1 ^ req_i.op2;
            end
            OR: begin
                legal  = logic_ok;
                result = req_i.op1 | req_i.op2;
            end
            AND: begin
                legal  = logic_ok;
                result = req_i.op1 & req_i.op2;
            end
            default: legal = 1'b0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wb_o.valid <= 1'b0;
        end else begin
            wb_o.valid <= accept_i && is_alu && legal && req_i.rd_we;
        end
        if (accept_i) begin
            wb_o.rd   <= req_i.rd;
            wb_o.data <= result;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/branch_unit.sv ====
// conditional branch evaluation for the six RV64I branches
// a taken branch gives a one-cycle redirect pulse with its target
`timescale 1ns/1ps
`default_nettype none

module branch_unit (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    accept_i,
    input  ex_stage_pkg::ex_req_t   req_i,
    output ex_stage_pkg::redirect_t redirect_o
);

    import rv_isa_pkg::*;

    branch_funct3_e funct3;
    logic           is_branch;
    logic           taken;
    xlen_t          imm_b;

    assign funct3    = branch_funct3_e'(req_i.inst[14:12]);
    assign is_branch = (opcode_e'(req_i.inst[6:0]) == BRANCH);
    assign imm_b = {{51{req_i.inst[31]}}, req_i.inst[31], req_i.inst[7],
                    req_i.inst[30:25], req_i.inst[11:8], 1'b0};

    always_comb begin
        case (funct3)
            BEQ:     taken = (req_i.op1 == req_i.op2);
            BNE:     taken = (req_i.op1 != req_i.op2);
            BLT:     taken = ($signed(req_i.op1) < $signed(req_i.op2));
            BGE:     taken = ($signed(req_i.op1) >= $signed(req_i.op2));
            BLTU:    taken = (req_i.op1 < req_i.op2);
            BGEU:    taken = (req_i.op1 >= req_i.op2);
            default: taken = 1'b0;   // funct3 010/011 unused
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            redirect_o.valid <= 1'b0;
        end else begin
            redirect_o.valid <= accept_i && is_branch && taken;
        end
        if (accept_i) begin
            redirect_o.target <= req_i.pc + imm_b;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/mem_req_gen.sv ====
// load/store request generation with credit-based flow control
// holds the stage's ready; a memory op waits while no credit is left
`timescale 1ns/1ps
`default_nettype none

module mem_req_gen (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   valid_i,
    input  ex_stage_pkg::ex_req_t  req_i,
    output logic                   ready_o,
    output ex_stage_pkg::mem_req_t mem_req_o,
    input  logic                   mem_credit_i
);

    import rv_isa_pkg::*;
    import ex_stage_pkg::*;

    opcode_e     opcode;
    mem_size_e   size;
    logic        is_load;
    logic        is_store;
    logic        issue;
    xlen_t       imm_s;
    xlen_t       wdata;
    credit_cnt_t credit_cnt;

    assign opcode   = opcode_e'(req_i.inst[6:0]);
    assign size     = mem_size_e'(req_i.inst[14:12]);
    assign is_load  = (opcode == LOAD) && (size inside {BYTE, HALF, WORD, DOUBLE,
                                                        BYTE_U, HALF_U, WORD_U});
    assign is_store = (opcode == STORE) && (size inside {BYTE, HALF, WORD, DOUBLE});
    assign imm_s    = {{52{req_i.inst[31]}}, req_i.inst[31:25], req_i.inst[11:7]};

    // only memory ops need a credit
    assign ready_o = !(is_load || is_store) || (credit_cnt != '0);
    assign issue   = valid_i && ready_o && (is_load || is_store);

    always_comb begin
        case (size)
            BYTE:    wdata = {56'd0, req_i.op2[7:0]};
            HALF:    wdata = {48'd0, req_i.op2[15:0]};
            WORD:    wdata = {32'd0, req_i.op2[31:0]};
            default: wdata = req_i.op2;
        endcase
    end

    // return and issue in the same cycle cancel out
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            credit_cnt <= credit_cnt_t'(MEM_CREDITS);
        end else if (issue && !mem_credit_i) begin
            credit_cnt <= credit_cnt - 1'b1;
        end else if (!issue && mem_credit_i) begin
            credit_cnt <= credit_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            mem_req_o.valid <= 1'b0;
        end else begin
            mem_req_o.valid <= issue;
        end
        if (issue) begin
            mem_req_o.we    <= is_store;
            mem_req_o.size  <= size;
            mem_req_o.addr  <= req_i.op1 + (is_store ? imm_s : req_i.op2);
            mem_req_o.wdata <= is_store ? wdata : '0;
            mem_req_o.rd    <= is_load ? req_i.rd : '0;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/ex_stage.sv ====
// integer execute stage top
// ALU, branch and memory units run in parallel on each accepted instruction
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    valid_i,
    input  ex_stage_pkg::ex_req_t   req_i,
    output logic                    ready_o,
    output ex_stage_pkg::wb_t       wb_o,
    output ex_stage_pkg::redirect_t redirect_o,
    output ex_stage_pkg::mem_req_t  mem_req_o,
    input  logic                    mem_credit_i
);

    logic accept;

    assign accept = valid_i && ready_o;   // ready comes from the credit check

    int_alu u_int_alu (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .accept_i (accept),
        .req_i    (req_i),
        .wb_o     (wb_o)
    );

    branch_unit u_branch_unit (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .accept_i   (accept),
        .req_i      (req_i),
        .redirect_o (redirect_o)
    );

    mem_req_gen u_mem_req_gen (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .valid_i      (accept),
        .req_i        (req_i),
        .ready_o      (ready_o),
        .mem_req_o    (mem_req_o),
        .mem_credit_i (mem_credit_i)
    );

endmodule

`default_nettype wire

// ==== tb/tb_ex_stage.sv ====
// directed testbench for the integer execute stage
// runs ALU, branch, load/store and credit tests against a small RV64 model
`timescale 1ns/1ps
`default_nettype none

module tb_ex_stage;

    import rv_isa_pkg::*;
    import ex_stage_pkg::*;

    localparam int WAIT_LIMIT = 20;   // cycles

    logic      clk = 1'b0;
    logic      rst_n;
    logic      valid;
    ex_req_t   req;
    logic      ready;
    wb_t       wb;
    redirect_t redirect;
    mem_req_t  mem_req;
    logic      mem_credit;
    int        seed;

    ex_stage u_ex_stage (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .valid_i      (valid),
        .req_i        (req),
        .ready_o      (ready),
        .wb_o         (wb),
        .redirect_o   (redirect),
        .mem_req_o    (mem_req),
        .mem_credit_i (mem_credit)
    );

    always #5 clk = ~clk;

    task automatic abort_run();
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] exp,
                                   input logic [63:0] act);
        $display("ERR %s expected 0x%h actual 0x%h", name, exp, act);
        abort_run();
    endtask

    task automatic check_wb(input wb_t exp);
        if (exp.valid && wb.valid !== 1'b1) begin
            $display("wb_o.valid missing one cycle after acceptance");
            abort_run();
        end else if (wb.valid !== exp.valid)
            report_mismatch("wb_o.valid", 64'(exp.valid), 64'(wb.valid));
        else if (exp.valid && wb.rd !== exp.rd)
            report_mismatch("wb_o.rd", 64'(exp.rd), 64'(wb.rd));
        else if (exp.valid && wb.data !== exp.data)
            report_mismatch("wb_o.data", exp.data, wb.data);
    endtask

    task automatic check_redirect(input redirect_t exp);
        if (exp.valid && redirect.valid !== 1'b1) begin
            $display("redirect_o.valid missing for a taken branch");
            abort_run();
        end else if (redirect.valid !== exp.valid)
            report_mismatch("redirect_o.valid", 64'(exp.valid), 64'(redirect.valid));
        else if (exp.valid && redirect.target !== exp.target)
            report_mismatch("redirect_o.target", exp.target, redirect.target);
    endtask

    task automatic check_mem_req(input mem_req_t exp);
        if (exp.valid && mem_req.valid !== 1'b1) begin
            $display("mem_req_o.valid missing one cycle after acceptance");
            abort_run();
        end else if (mem_req.valid !== exp.valid)
            report_mismatch("mem_req_o.valid", 64'(exp.valid), 64'(mem_req.valid));
        else if (exp.valid && mem_req.we !== exp.we)
            report_mismatch("mem_req_o.we", 64'(exp.we), 64'(mem_req.we));
        else if (exp.valid && mem_req.size !== exp.size)
            report_mismatch("mem_req_o.size", 64'(exp.size), 64'(mem_req.size));
        else if (exp.valid && mem_req.addr !== exp.addr)
            report_mismatch("mem_req_o.addr", exp.addr, mem_req.addr);
        else if (exp.valid && exp.we && mem_req.wdata !== exp.wdata)
            report_mismatch("mem_req_o.wdata", exp.wdata, mem_req.wdata);
        else if (exp.valid && !exp.we && mem_req.rd !== exp.rd)
            report_mismatch("mem_req_o.rd", 64'(exp.rd), 64'(mem_req.rd));
    endtask

    // holds the current request until ready_o is seen, then drops valid
    task automatic wait_accept();
        int n;
        n = 0;
        @(negedge clk);
        while (ready !== 1'b1) begin
            n++;
            if (n > WAIT_LIMIT) begin
                $display("timeout, instruction not accepted within %0d cycles", WAIT_LIMIT);
                abort_run();
            end
            @(negedge clk);
        end
        @(posedge clk);
        valid <= 1'b0;
    endtask

    task automatic issue(input ex_req_t r);
        @(posedge clk);
        valid <= 1'b1;
        req   <= r;
        wait_accept();
    endtask

    task automatic return_credit();
        @(posedge clk);
        mem_credit <= 1'b1;
        @(posedge clk);
        mem_credit <= 1'b0;
    endtask

    function automatic xlen_t rand64();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic ex_req_t make_req(input inst_t inst, input xlen_t op1, input xlen_t op2);
        ex_req_t r;
        r.inst  = inst;
        r.pc    = rand64() & ~64'h3;
        r.op1   = op1;
        r.op2   = op2;
        r.rd    = inst[11:7];
        r.rd_we = (inst[6:0] != BRANCH) && (inst[6:0] != STORE);
        return r;
    endfunction

    // RV64I ALU rules with the W forms sign extended from the low word
    function automatic wb_t alu_model(input ex_req_t r);
        wb_t         e;
        logic        alt;
        logic        imm;
        logic        w;
        logic [5:0]  sh;
        logic [31:0] a32;
        logic [31:0] t32;
        xlen_t       d;
        alt = r.inst[30];
        imm = (r.inst[6:0] == OP_IMM) || (r.inst[6:0] == OP_IMM_32);
        w   = (r.inst[6:0] == OP_32) || (r.inst[6:0] == OP_IMM_32);
        sh  = imm ? r.inst[25:20] : r.op2[5:0];
        a32 = r.op1[31:0];
        case (r.inst[14:12])
            3'b000: d = (alt && !imm) ? r.op1 - r.op2 : r.op1 + r.op2;
            3'b001: d = r.op1 << sh;
            3'b010: d = {63'd0, $signed(r.op1) < $signed(r.op2)};
            3'b011: d = {63'd0, r.op1 < r.op2};
            3'b100: d = r.op1 ^ r.op2;
            3'b101: begin
                if (alt)
                    d = $signed(r.op1) >>> sh;
                else
                    d = r.op1 >> sh;
            end
            3'b110: d = r.op1 | r.op2;
            default: d = r.op1 & r.op2;
        endcase
        if (w) begin
            case (r.inst[14:12])
                3'b001: t32 = a32 << sh[4:0];
                3'b101: begin
                    if (alt)
                        t32 = $signed(a32) >>> sh[4:0];
                    else
                        t32 = a32 >> sh[4:0];
                end
                default: t32 = d[31:0];   // addw, subw
            endcase
            d = {{32{t32[31]}}, t32};
        end
        e.valid = 1'b1;
        e.rd    = r.rd;
        e.data  = d;
        return e;
    endfunction

    function automatic mem_req_t load_expect(input ex_req_t r);
        mem_req_t e;
        e.valid = 1'b1;
        e.we    = 1'b0;
        e.size  = mem_size_e'(r.inst[14:12]);
        e.addr  = r.op1 + r.op2;
        e.wdata = '0;
        e.rd    = r.rd;
        return e;
    endfunction

    function automatic mem_req_t store_expect(input ex_req_t r);
        mem_req_t    e;
        logic [11:0] imm12;
        imm12   = {r.inst[31:25], r.inst[11:7]};
        e.valid = 1'b1;
        e.we    = 1'b1;
        e.size  = mem_size_e'(r.inst[14:12]);
        e.addr  = r.op1 + {{52{imm12[11]}}, imm12};
        case (r.inst[14:12])
            3'b000: e.wdata = r.op2 & 64'h0000_0000_0000_00ff;
            3'b001: e.wdata = r.op2 & 64'h0000_0000_0000_ffff;
            3'b010: e.wdata = r.op2 & 64'h0000_0000_ffff_ffff;
            default: e.wdata = r.op2;
        endcase
        e.rd = '0;
        return e;
    endfunction

    task automatic after_reset();
        @(negedge clk);
        check_wb('0);
        check_redirect('0);
        check_mem_req('0);
        // a waiting load makes ready depend on the reset credit count
        @(posedge clk);
        req <= make_req({12'd0, 5'd1, 3'b011, 5'd4, LOAD}, 64'd0, 64'd0);
        @(negedge clk);
        if (ready !== 1'b1)
            report_mismatch("ready_o", 64'd1, 64'(ready));
    endtask

    task automatic alu_ops();
        opcode_e     opc;
        logic        imm;
        logic        w;
        logic [11:0] imm12;
        logic [5:0]  sh;
        reg_addr_t   rd;
        inst_t       inst;
        ex_req_t     r;
        for (int i = 0; i < 4; i++) begin
            case (i)
                0: opc = OP;
                1: opc = OP_IMM;
                2: opc = OP_32;
                default: opc = OP_IMM_32;
            endcase
            imm = (opc == OP_IMM) || (opc == OP_IMM_32);
            w   = (opc == OP_32) || (opc == OP_IMM_32);
            for (int f = 0; f < 8; f++) begin
                for (int a = 0; a < 2; a++) begin
                    if (w && !(f inside {0, 1, 5}))
                        continue;   // no W form
                    if (a == 1 && !(f == 5 || (f == 0 && !imm)))
                        continue;
                    imm12 = 12'($random(seed));
                    sh    = 6'($random(seed));
                    rd    = 5'($random(seed));
                    if (imm && (f == 1 || f == 5) && w)
                        imm12 = {1'b0, a[0], 5'd0, sh[4:0]};
                    else if (imm && (f == 1 || f == 5))
                        imm12 = {1'b0, a[0], 4'd0, sh};
                    if (imm)
                        inst = {imm12, 5'd1, f[2:0], rd, opc};
                    else
                        inst = {a[0] ? FUNCT7_ALT : FUNCT7_BASE, 5'd2, 5'd1, f[2:0], rd, opc};
                    r = make_req(inst, rand64(), imm ? {{52{imm12[11]}}, imm12} : rand64());
                    issue(r);
                    @(negedge clk);
                    check_wb(alu_model(r));
                    check_redirect('0);
                end
            end
        end
        // mul encoding is not supported here
        issue(make_req({7'b0000001, 5'd2, 5'd1, 3'b000, 5'd3, OP}, rand64(), rand64()));
        @(negedge clk);
        check_wb('0);
    endtask

    task automatic back_to_back();
        ex_req_t r [3];
        for (int i = 0; i < 3; i++)
            r[i] = make_req({FUNCT7_BASE, 5'd2, 5'd1, 3'(i * 2), 5'(i + 5), OP},
                            rand64(), rand64());
        @(posedge clk);
        valid <= 1'b1;
        req   <= r[0];
        for (int i = 0; i < 3; i++) begin
            @(negedge clk);
            if (ready !== 1'b1) begin
                $display("ALU instruction stalled in a back-to-back sequence");
                abort_run();
            end
            if (i > 0)
                check_wb(alu_model(r[i - 1]));
            @(posedge clk);
            if (i < 2)
                req <= r[i + 1];
            else
                valid <= 1'b0;
        end
        @(negedge clk);
        check_wb(alu_model(r[2]));
    endtask

    task automatic branches();
        logic [12:0] off;
        xlen_t       a;
        xlen_t       b;
        ex_req_t     r;
        redirect_t   exp;
        for (int f = 0; f < 8; f++) begin
            if (f == 2 || f == 3)
                continue;
            // pairs give every branch a taken and a not-taken case
            for (int p = 0; p < 3; p++) begin
                case (p)
                    0: begin
                        a = 64'd5;
                        b = 64'd5;
                    end
                    1: begin
                        a = 64'd1;
                        b = '1;
                    end
                    default: begin
                        a = '1;
                        b = 64'd1;
                    end
                endcase
                off    = 13'($random(seed));
                off[0] = 1'b0;
                case (f)
                    0: exp.valid = (a == b);
                    1: exp.valid = (a != b);
                    4: exp.valid = $signed(a) < $signed(b);
                    5: exp.valid = $signed(a) >= $signed(b);
                    6: exp.valid = a < b;
                    default: exp.valid = a >= b;
                endcase
                r = make_req({off[12], off[10:5], 5'd2, 5'd1, f[2:0], off[4:1], off[11], BRANCH},
                             a, b);
                exp.target = r.pc + {{51{off[12]}}, off};
                issue(r);
                @(negedge clk);
                check_redirect(exp);
                check_wb('0);
            end
        end
    endtask

    task automatic loads_stores();
        logic [11:0] imm12;
        ex_req_t     r;
        for (int s = 0; s < 7; s++) begin
            imm12 = 12'($random(seed));
            r = make_req({imm12, 5'd1, s[2:0], 5'(s + 8), LOAD}, rand64(),
                         {{52{imm12[11]}}, imm12});
            issue(r);
            @(negedge clk);
            check_mem_req(load_expect(r));
            check_wb('0);   // loads write back later
            return_credit();
            if (s < 4) begin
                r = make_req({imm12[11:5], 5'd2, 5'd1, s[2:0], imm12[4:0], STORE},
                             rand64(), rand64());
                issue(r);
                @(negedge clk);
                check_mem_req(store_expect(r));
                return_credit();
            end
        end
    endtask

    task automatic credit_stall();
        ex_req_t st [MEM_CREDITS + 1];
        ex_req_t alu;
        for (int i = 0; i <= MEM_CREDITS; i++)
            st[i] = make_req({7'd0, 5'd2, 5'd1, 3'b011, 5'(i * 8), STORE}, rand64(), rand64());
        alu = make_req({FUNCT7_BASE, 5'd2, 5'd1, 3'b110, 5'd9, OP}, rand64(), rand64());
        for (int i = 0; i < MEM_CREDITS; i++) begin
            issue(st[i]);
            @(negedge clk);
            check_mem_req(store_expect(st[i]));
        end
        @(posedge clk);
        valid <= 1'b1;
        req   <= st[MEM_CREDITS];
        repeat (4) begin
            @(negedge clk);
            if (ready !== 1'b0) begin
                $display("ready_o high for a store with no credits left");
                abort_run();
            end
        end
        @(posedge clk);
        req <= alu;   // ALU op slips past the stalled store
        wait_accept();
        valid <= 1'b1;
        req   <= st[MEM_CREDITS];
        @(negedge clk);
        check_wb(alu_model(alu));
        return_credit();
        wait_accept();
        @(negedge clk);
        check_mem_req(store_expect(st[MEM_CREDITS]));
        repeat (MEM_CREDITS) return_credit();
    endtask

    initial begin
        seed       = 79;
        rst_n      <= 1'b0;
        valid      <= 1'b0;
        req        <= '0;
        mem_credit <= 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        after_reset();
        alu_ops();
        back_to_back();
        branches();
        loads_stores();
        credit_stall();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
hdl/rv_isa_pkg.sv
hdl/ex_stage_pkg.sv
hdl/int_alu.sv
hdl/branch_unit.sv
hdl/mem_req_gen.sv
hdl/ex_stage.sv
tb/tb_ex_stage.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_ex_stage
FLIST     := flist.f
OBJ_DIR   := obj_dir
FLAGS     := --binary --timing -Wno-fatal --top-module $(TOP) -Mdir $(OBJ_DIR)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) -f $(FLIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
